/* secure_mem_subsys.f */
+incdir+hdl
hdl/smem_pkg.sv
hdl/req_arbiter.sv
hdl/access_check.sv
hdl/dma_engine.sv
hdl/line_memory.sv
hdl/mem_ctrl.sv
hdl/secure_mem_subsys.sv
testbench/tb_secure_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_secure_mem_subsys -Mdir obj_dir -f secure_mem_subsys.f
if [ $? -ne 0 ]; then
	echo "verilator build error"
	exit 1
fi

./obj_dir/Vtb_secure_mem_subsys > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" "$log"; then
	exit 1
fi
exit 0

/* testbench/tb_secure_mem_subsys.sv */
// testbench for the two-domain secure memory subsystem
// drives both Wishbone ports from an LFSR and checks every response against a word model

`timescale 1ns/1ps
`default_nettype none

`include "smem_consts.svh"

module tb_secure_mem_subsys;

	import smem_pkg::*;

	localparam int timeout_cycles = 2000;
	localparam logic [`SMEM_ADDR_BITS:0] part_adr =
		{1'b1, {(`SMEM_ADDR_BITS-1){1'b0}}, `SMEM_REG_PART};
	localparam logic [`SMEM_ADDR_BITS:0] dma_adr =
		{1'b1, {(`SMEM_ADDR_BITS-1){1'b0}}, `SMEM_REG_DMA};

	logic    clk;
	logic    reset;
	wb_req_t req0;
	wb_req_t req1;
	wb_rsp_t rsp0;
	wb_rsp_t rsp1;

	logic [15:0] lfsr_q = 16'd11099;
	logic [`SMEM_DATA_BITS-1:0] model_mem [0:`SMEM_DEPTH-1];
	logic [`SMEM_ADDR_BITS-1:0] model_bnd;
	int checks = 0;
	int errors = 0;
	int t_checks;
	int t_errors;

	secure_mem_subsys DUT (
		.clk   (clk),
		.reset (reset),
		.req0  (req0),
		.req1  (req1),
		.rsp0  (rsp0),
		.rsp1  (rsp1)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//======================================================================
	// random numbers and reference model
	//======================================================================

	// taps x^16 + x^14 + x^13 + x^11 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic in_region(input logic port, input int addr);
		if (addr >= `SMEM_DEPTH) begin
			return 1'b0;
		end
		if (port) begin
			return addr >= int'(model_bnd);
		end
		return addr < int'(model_bnd);
	endfunction

	function automatic logic owner_port(input logic [`SMEM_ADDR_BITS-1:0] a);
		return (a < model_bnd) ? 1'b0 : 1'b1;
	endfunction

	// start of a block of len words inside the port's region
	function automatic logic [`SMEM_ADDR_BITS-1:0] block_start(input logic port, input int len);
		int lo;
		int size;
		int r;
		lo   = port ? int'(model_bnd) : 0;
		size = port ? `SMEM_DEPTH - int'(model_bnd) : int'(model_bnd);
		r    = int'(rand_bits(10)) % (size - len + 1);
		return `SMEM_ADDR_BITS'(lo + r);
	endfunction

	function automatic logic [`SMEM_DATA_BITS-1:0] fill_word(input logic [`SMEM_ADDR_BITS-1:0] a);
		return {a, ~a, 12'h5a3};
	endfunction

	function automatic logic [`SMEM_DATA_BITS-1:0] dma_word(input logic [`SMEM_ADDR_BITS-1:0] src,
		input logic [`SMEM_ADDR_BITS-1:0] dst, input logic [`SMEM_LEN_BITS-1:0] len);
		cmd_word_u c;
		c.word    = '0;
		c.dma.src = src;
		c.dma.dst = dst;
		c.dma.len = len;
		return c.word;
	endfunction

	// expected response of one transaction with the model updated as a side effect
	function automatic wb_rsp_t model_apply(input logic port, input logic we,
		input logic [`SMEM_ADDR_BITS:0] adr, input logic [`SMEM_DATA_BITS-1:0] dat);
		wb_rsp_t exp;
		cmd_word_u c;
		int a;
		int src;
		int dst;
		int len;
		logic ok;
		exp = '0;
		c.word = dat;
		a = int'(adr[`SMEM_ADDR_BITS-1:0]);
		if (!adr[`SMEM_ADDR_BITS]) begin
			if (!in_region(port, a)) begin
				exp.err = 1'b1;
			end else if (we) begin
				exp.ack = 1'b1;
				model_mem[a] = dat;
			end else begin
				exp.ack = 1'b1;
				exp.dat = model_mem[a];
			end
		end else if (!we) begin
			exp.err = 1'b1;
		end else if (adr[0] == `SMEM_REG_PART) begin
			if (port) begin
				exp.err = 1'b1;
			end else begin
				exp.ack = 1'b1;
				model_bnd = dat[`SMEM_ADDR_BITS-1:0];
			end
		end else begin
			src = int'(c.dma.src);
			dst = int'(c.dma.dst);
			len = int'(c.dma.len);
			ok = 1'b1;
			for (int i = 0; i < len; i++) begin
				if (!in_region(port, src + i) || !in_region(port, dst + i)) begin
					ok = 1'b0;
				end
			end
			exp.ack = ok;
			exp.err = !ok;
			// copy runs forward one word at a time
			for (int i = 0; ok && i < len; i++) begin
				model_mem[dst + i] = model_mem[src + i];
			end
		end
		return exp;
	endfunction

	//======================================================================
	// checks and bus access
	//======================================================================

	task automatic check_rsp(input string what, input wb_rsp_t got, input wb_rsp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got ack=%b err=%b dat=%h, expected ack=%b err=%b dat=%h",
				$time, what, got.ack, got.err, got.dat, exp.ack, exp.err, exp.dat);
		end
	endtask

	task automatic check_word(input string what, input logic [`SMEM_DATA_BITS-1:0] got,
		input logic [`SMEM_DATA_BITS-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$finish;
	endtask

	// one Wishbone classic cycle with stb held until ack or err
	task automatic wb_cycle(input logic port, input logic we, input logic [`SMEM_ADDR_BITS:0] adr,
		input logic [`SMEM_DATA_BITS-1:0] dat, output wb_rsp_t got);
		wb_req_t r;
		wb_rsp_t s;
		int cycles;
		r = '0;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we  = we;
		r.adr = adr;
		r.dat = dat;
		s = '0;
		cycles = 0;
		@(posedge clk);
		if (port) begin
			req1 <= r;
		end else begin
			req0 <= r;
		end
		while (!(s.ack || s.err) && cycles < timeout_cycles) begin
			@(negedge clk);
			s = port ? rsp1 : rsp0;
			cycles++;
		end
		got = s;
		if (!(s.ack || s.err)) begin
			abort_run($sformatf("timeout: port %0d saw no ack or err within %0d cycles",
				port, timeout_cycles));
		end else begin
			@(posedge clk);
			if (port) begin
				req1 <= '0;
			end else begin
				req0 <= '0;
			end
		end
	endtask

	task automatic expect_access(input logic port, input logic we,
		input logic [`SMEM_ADDR_BITS:0] adr, input logic [`SMEM_DATA_BITS-1:0] dat,
		output wb_rsp_t got);
		wb_rsp_t exp;
		exp = model_apply(port, we, adr, dat);
		wb_cycle(port, we, adr, dat, got);
		check_rsp($sformatf("rsp%0d %s adr %h", port, we ? "write" : "read", adr), got, exp);
	endtask

	task automatic random_op(input logic port, input logic own);
		wb_rsp_t got;
		logic [31:0] r;
		logic [`SMEM_ADDR_BITS-1:0] a;
		logic [`SMEM_DATA_BITS-1:0] d;
		r = rand_bits(11);
		a = own ? block_start(port, 1) : r[`SMEM_ADDR_BITS-1:0];
		d = rand_bits(32);
		expect_access(port, r[10], {1'b0, a}, d, got);
	endtask

	task automatic readback_range(input logic [`SMEM_ADDR_BITS-1:0] start, input int n);
		wb_rsp_t got;
		logic [`SMEM_ADDR_BITS-1:0] a;
		for (int i = 0; i < n; i++) begin
			a = start + `SMEM_ADDR_BITS'(i);
			expect_access(owner_port(a), 1'b0, {1'b0, a}, '0, got);
		end
	endtask

	// reads by both ports on either side of the boundary
	task automatic probe_boundary();
		wb_rsp_t got;
		logic [`SMEM_ADDR_BITS-1:0] a;
		a = model_bnd - 10'd1;
		expect_access(1'b0, 1'b0, {1'b0, a}, '0, got);
		expect_access(1'b1, 1'b0, {1'b0, a}, '0, got);
		a = model_bnd;
		expect_access(1'b0, 1'b0, {1'b0, a}, '0, got);
		expect_access(1'b1, 1'b0, {1'b0, a}, '0, got);
	endtask

	task automatic start_test();
		t_checks = checks;
		t_errors = errors;
	endtask

	task automatic end_test(input int n, input string name);
		$display("test %0d %s: %0d checks, %0d errors", n, name,
			checks - t_checks, errors - t_errors);
	endtask

	//======================================================================
	// tests
	//======================================================================

	task automatic own_region_traffic();
		wb_rsp_t got;
		logic [`SMEM_ADDR_BITS-1:0] a;
		@(negedge clk);
		check_bit("rsp0.ack after reset", rsp0.ack, 1'b0);
		check_bit("rsp0.err after reset", rsp0.err, 1'b0);
		check_bit("rsp1.ack after reset", rsp1.ack, 1'b0);
		check_bit("rsp1.err after reset", rsp1.err, 1'b0);
		// every word written once by its owner
		for (int i = 0; i < `SMEM_DEPTH; i++) begin
			a = `SMEM_ADDR_BITS'(i);
			expect_access(owner_port(a), 1'b1, {1'b0, a}, fill_word(a), got);
		end
		for (int k = 0; k < 80; k++) begin
			random_op(k[0], 1'b1);
		end
	endtask

	task automatic cross_region_traffic();
		wb_rsp_t got;
		logic [`SMEM_ADDR_BITS-1:0] a;
		logic [`SMEM_DATA_BITS-1:0] d;
		logic p;
		for (int k = 0; k < 16; k++) begin
			p = k[0];
			a = block_start(~p, 1);
			d = rand_bits(32);
			expect_access(p, 1'b1, {1'b0, a}, d, got);
			// owner still sees the old word
			expect_access(~p, 1'b0, {1'b0, a}, '0, got);
			a = block_start(~p, 1);
			expect_access(p, 1'b0, {1'b0, a}, '0, got);
			check_word("rsp dat on refused read", got.dat, '0);
		end
	endtask

	task automatic partition_moves();
		wb_rsp_t got;
		logic [31:0] r;
		// new boundary always below the reset value
		r = rand_bits(8);
		expect_access(1'b0, 1'b1, part_adr, {22'd0, 10'd256 + `SMEM_ADDR_BITS'(r[7:0])}, got);
		probe_boundary();
		r = rand_bits(10);
		expect_access(1'b1, 1'b1, part_adr, r, got);
		probe_boundary();
		expect_access(1'b0, 1'b0, part_adr, '0, got);
		for (int k = 0; k < 60; k++) begin
			random_op(k[0], 1'b0);
		end
	endtask

	task automatic dma_copies();
		wb_rsp_t got;
		logic [`SMEM_ADDR_BITS-1:0] src;
		logic [`SMEM_ADDR_BITS-1:0] dst;
		logic [`SMEM_LEN_BITS-1:0] len;
		logic p;
		for (int k = 0; k < 4; k++) begin
			p = k[0];
			len = `SMEM_LEN_BITS'(rand_bits(4)) + 8'd1;
			src = block_start(p, int'(len));
			dst = block_start(p, int'(len));
			expect_access(p, 1'b1, dma_adr, dma_word(src, dst, len), got);
			readback_range(dst, int'(len));
		end
		// destination runs into domain 1
		dst = model_bnd - 10'd4;
		expect_access(1'b0, 1'b1, dma_adr, dma_word(10'd0, dst, 8'd8), got);
		readback_range(dst, 8);
		// source in domain 0
		src = model_bnd - 10'd2;
		dst = model_bnd + 10'd10;
		expect_access(1'b1, 1'b1, dma_adr, dma_word(src, dst, 8'd4), got);
		readback_range(dst, 4);
		// past the last word
		expect_access(1'b1, 1'b1, dma_adr, dma_word(10'd1020, 10'd900, 8'd8), got);
		readback_range(10'd900, 8);
		expect_access(1'b1, 1'b1, dma_adr, dma_word(model_bnd, model_bnd + 10'd1, 8'd0), got);
	endtask

	initial begin
		reset = 1'b1;
		req0  = '0;
		req1  = '0;
		model_bnd = `SMEM_PART_RESET;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		start_test();
		own_region_traffic();
		end_test(1, "reset and own-region access");
		start_test();
		cross_region_traffic();
		end_test(2, "cross-region access");
		start_test();
		partition_moves();
		end_test(3, "partition register");
		start_test();
		dma_copies();
		end_test(4, "DMA copy");

		// both masters hold stb together
		start_test();
		fork
			begin
				for (int k = 0; k < 60; k++) begin
					random_op(1'b0, 1'b0);
				end
			end
			begin
				for (int k = 0; k < 60; k++) begin
					random_op(1'b1, 1'b0);
				end
			end
		join
		end_test(5, "concurrent ports");

		$display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/secure_mem_subsys.sv */
// top of the two-domain secure memory subsystem
// Wishbone port 0 is the trusted domain, port 1 the other domain

`timescale 1ns/1ps
`default_nettype none

`include "smem_consts.svh"

module secure_mem_subsys (
	input  logic              clk,
	input  logic              reset,
	input  smem_pkg::wb_req_t req0,
	input  smem_pkg::wb_req_t req1,
	output smem_pkg::wb_rsp_t rsp0,
	output smem_pkg::wb_rsp_t rsp1
);

	import smem_pkg::*;

	wb_req_t granted;
	logic    grant;
	wb_rsp_t ctrl_rsp;
	logic    ctrl_done;

	logic [`SMEM_ADDR_BITS-1:0] chk_first;
	logic [`SMEM_ADDR_BITS-1:0] chk_last;
	logic                       chk_allow;
	logic                       part_we;

	logic                       dma_load;
	logic                       dma_step;
	logic [`SMEM_ADDR_BITS-1:0] dma_src;
	logic [`SMEM_ADDR_BITS-1:0] dma_dst;
	logic                       dma_last;

	mem_op_t                    mem_op;
	logic [`SMEM_DATA_BITS-1:0] mem_rdata;

	req_arbiter u_arbiter (
		.clk        (clk),
		.reset      (reset),
		.req0       (req0),
		.req1       (req1),
		.rsp0       (rsp0),
		.rsp1       (rsp1),
		.granted    (granted),
		.grant      (grant),
		.busy_done  (ctrl_done),
		.rsp        (ctrl_rsp)
	);

	access_check u_access (
		.clk        (clk),
		.reset      (reset),
		.domain     (grant),
		.first_addr (chk_first),
		.last_addr  (chk_last),
		.part_we    (part_we),
		.part_wdata (granted.dat[`SMEM_ADDR_BITS-1:0]),
		.allow      (chk_allow)
	);

	dma_engine u_dma (
		.clk        (clk),
		.reset      (reset),
		.load       (dma_load),
		.cmd        (granted.dat),
		.step       (dma_step),
		.src_addr   (dma_src),
		.dst_addr   (dma_dst),
		.last       (dma_last)
	);

	line_memory u_memory (
		.clk        (clk),
		.op         (mem_op),
		.rdata      (mem_rdata)
	);

	mem_ctrl u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.req        (granted),
		.domain     (grant),
		.rsp        (ctrl_rsp),
		.done       (ctrl_done),
		.first_addr (chk_first),
		.last_addr  (chk_last),
		.allow      (chk_allow),
		.part_we    (part_we),
		.dma_load   (dma_load),
		.dma_step   (dma_step),
		.dma_src    (dma_src),
		.dma_dst    (dma_dst),
		.dma_last   (dma_last),
		.op         (mem_op),
		.rdata      (mem_rdata)
	);

endmodule

`default_nettype wire

/* hdl/mem_ctrl.sv */
// control FSM for the secure memory subsystem
// runs one granted Wishbone transaction as a plain access, a register write or a DMA copy

`timescale 1ns/1ps
`default_nettype none

`include "smem_consts.svh"

module mem_ctrl (
	input  logic                       clk,
	input  logic                       reset,
	input  smem_pkg::wb_req_t          req,
	input  logic                       domain,
	output smem_pkg::wb_rsp_t          rsp,
	output logic                       done,
	output logic [`SMEM_ADDR_BITS-1:0] first_addr,
	output logic [`SMEM_ADDR_BITS-1:0] last_addr,
	input  logic                       allow,
	output logic                       part_we,
	output logic                       dma_load,
	output logic                       dma_step,
	input  logic [`SMEM_ADDR_BITS-1:0] dma_src,
	input  logic [`SMEM_ADDR_BITS-1:0] dma_dst,
	input  logic                       dma_last,
	output smem_pkg::mem_op_t          op,
	input  logic [`SMEM_DATA_BITS-1:0] rdata
);

	import smem_pkg::*;

	typedef enum logic [2:0] {
		idle, check, read, respond, dma_read, dma_write
	} state_t;

	state_t state;
	state_t state_nxt;
	logic fail_q;
	logic fail_nxt;
	logic [`SMEM_DATA_BITS-1:0] dat_q;

	logic reg_space;
	logic reg_sel;
	logic [`SMEM_ADDR_BITS-1:0] word_addr;
	cmd_word_u cmd_w;
	logic [`SMEM_ADDR_BITS-1:0] lo_addr;
	logic [`SMEM_ADDR_BITS-1:0] hi_addr;
	logic [`SMEM_ADDR_BITS:0] span_end;

	//======================================================================
	// request decode
	//======================================================================

	assign reg_space  = req.adr[`SMEM_ADDR_BITS];
	assign reg_sel    = req.adr[0];
	assign word_addr  = req.adr[`SMEM_ADDR_BITS-1:0];
	assign cmd_w.word = req.dat;

	// one check covers both copy ranges from the lower start to the higher end
	assign lo_addr  = (cmd_w.dma.src < cmd_w.dma.dst) ? cmd_w.dma.src : cmd_w.dma.dst;
	assign hi_addr  = (cmd_w.dma.src < cmd_w.dma.dst) ? cmd_w.dma.dst : cmd_w.dma.src;
	assign span_end = {1'b0, hi_addr}
		+ {{(`SMEM_ADDR_BITS+1-`SMEM_LEN_BITS){1'b0}}, cmd_w.dma.len} - 1'b1;

	assign first_addr = reg_space ? lo_addr : word_addr;
	assign last_addr  = reg_space ? span_end[`SMEM_ADDR_BITS-1:0] : word_addr;

	//======================================================================
	// FSM
	//======================================================================

	always_comb begin
		state_nxt = state;
		fail_nxt  = fail_q;
		part_we   = 1'b0;
		dma_load  = 1'b0;
		dma_step  = 1'b0;
		op        = '0;
		case (state)
			idle: begin
				if (req.cyc && req.stb) begin
					state_nxt = check;
				end
			end
			check: begin
				// err unless a case below accepts it
				fail_nxt  = 1'b1;
				state_nxt = respond;
				if (!reg_space) begin
					if (allow) begin
						fail_nxt = 1'b0;
						op.en    = 1'b1;
						op.we    = req.we;
						op.addr  = word_addr;
						op.wdata = req.dat;
						if (!req.we) begin
							state_nxt = read;
						end
					end
				end else if (req.we) begin
					case (reg_sel)
						`SMEM_REG_PART: begin
							if (!domain) begin
								fail_nxt = 1'b0;
								part_we  = 1'b1;
							end
						end
						`SMEM_REG_DMA: begin
							if (cmd_w.dma.len == '0) begin
								fail_nxt = 1'b0;
							end else if (allow && !span_end[`SMEM_ADDR_BITS]) begin
								fail_nxt  = 1'b0;
								dma_load  = 1'b1;
								state_nxt = dma_read;
							end
						end
					endcase
				end
			end
			read: begin
				state_nxt = respond;
			end
			dma_read: begin
				op.en     = 1'b1;
				op.addr   = dma_src;
				state_nxt = dma_write;
			end
			dma_write: begin
				op.en    = 1'b1;
				op.we    = 1'b1;
				op.addr  = dma_dst;
				op.wdata = rdata;
				dma_step = 1'b1;
				state_nxt = dma_last ? respond : dma_read;
			end
			respond: begin
				state_nxt = idle;
			end
			default: begin
				state_nxt = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= idle;
			fail_q <= 1'b0;
		end else begin
			state  <= state_nxt;
			fail_q <= fail_nxt;
		end
	end

	// zero unless a plain read returns a word
	always_ff @(posedge clk) begin
		if (state == check) begin
			dat_q <= '0;
		end else if (state == read) begin
			dat_q <= rdata;
		end
	end

	assign done = (state == respond);
	assign rsp  = '{ack: done && !fail_q, err: done && fail_q, dat: dat_q};

	// copy addresses stay inside the range that was checked
	a_dma_in_span: assert property (@(posedge clk) disable iff (reset)
		(state == dma_read || state == dma_write)
		|-> dma_src >= first_addr && dma_src <= last_addr
			&& dma_dst >= first_addr && dma_dst <= last_addr)
		else $error("DMA address outside the checked range");

endmodule

`default_nettype wire

/* hdl/line_memory.sv */
// shared word memory, one port
// write on en and we, read data registered and valid the next cycle

`timescale 1ns/1ps
`default_nettype none

`include "smem_consts.svh"

module line_memory (
	input  logic                       clk,
	input  smem_pkg::mem_op_t          op,
	output logic [`SMEM_DATA_BITS-1:0] rdata
);

	logic [`SMEM_DATA_BITS-1:0] mem [0:`SMEM_DEPTH-1];

	// read returns the old word on a write
	always_ff @(posedge clk) begin
		if (op.en) begin
			if (op.we) begin
				mem[op.addr] <= op.wdata;
			end
			rdata <= mem[op.addr];
		end
	end

endmodule

`default_nettype wire

/* hdl/dma_engine.sv */
// DMA address and count registers
// loaded from a command word, then stepped once per copied word

`timescale 1ns/1ps
`default_nettype none

`include "smem_consts.svh"

module dma_engine (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       load,
	input  smem_pkg::cmd_word_u        cmd,
	input  logic                       step,
	output logic [`SMEM_ADDR_BITS-1:0] src_addr,
	output logic [`SMEM_ADDR_BITS-1:0] dst_addr,
	output logic                       last
);

	logic [`SMEM_ADDR_BITS-1:0] src_q;
	logic [`SMEM_ADDR_BITS-1:0] dst_q;
	logic [`SMEM_LEN_BITS-1:0]  remain;

	always_ff @(posedge clk) begin
		if (load) begin
			src_q <= cmd.dma.src;
			dst_q <= cmd.dma.dst;
		end else if (step) begin
			src_q <= src_q + 1'b1;
			dst_q <= dst_q + 1'b1;
		end
	end

	// words still to copy
	always_ff @(posedge clk) begin
		if (reset) begin
			remain <= '0;
		end else if (load) begin
			remain <= cmd.dma.len;
		end else if (step) begin
			remain <= remain - 1'b1;
		end
	end

	assign src_addr = src_q;
	assign dst_addr = dst_q;
	assign last     = (remain == `SMEM_LEN_BITS'(1));

	// controller stops stepping once the count is spent
	a_no_overstep: assert property (@(posedge clk) disable iff (reset)
		step |-> remain != '0)
		else $error("DMA step with no words left");

endmodule

`default_nettype wire

/* hdl/access_check.sv */
// partition register and domain check for an address range
// domain 0 owns words below the boundary, domain 1 the rest

`timescale 1ns/1ps
`default_nettype none

`include "smem_consts.svh"

module access_check (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       domain,
	input  logic [`SMEM_ADDR_BITS-1:0] first_addr,
	input  logic [`SMEM_ADDR_BITS-1:0] last_addr,
	input  logic                       part_we,
	input  logic [`SMEM_ADDR_BITS-1:0] part_wdata,
	output logic                       allow
);

	logic [`SMEM_ADDR_BITS-1:0] boundary;
	logic first_low;
	logic last_low;

	always_ff @(posedge clk) begin
		if (reset) begin
			boundary <= `SMEM_PART_RESET;
		end else if (part_we) begin
			boundary <= part_wdata;
		end
	end

	assign first_low = first_addr < boundary;
	assign last_low  = last_addr < boundary;

	// regions are contiguous so both ends decide the whole range
	always_comb begin
		if (domain) begin
			allow = !first_low && !last_low;
		end else begin
			allow = first_low && last_low;
		end
	end

	// only the trusted side may move the boundary
	a_part_owner: assert property (@(posedge clk) disable iff (reset)
		part_we |-> !domain)
		else $error("partition write from domain 1");

endmodule

`default_nettype wire

/* hdl/req_arbiter.sv */
// round-robin arbiter for the two Wishbone slave ports
// port 0 is domain 0, port 1 is domain 1; the grant index is the domain

`timescale 1ns/1ps
`default_nettype none

module req_arbiter (
	input  logic             clk,
	input  logic             reset,
	input  smem_pkg::wb_req_t req0,
	input  smem_pkg::wb_req_t req1,
	output smem_pkg::wb_rsp_t rsp0,
	output smem_pkg::wb_rsp_t rsp1,
	output smem_pkg::wb_req_t granted,
	output logic             grant,
	input  logic             busy_done,
	input  smem_pkg::wb_rsp_t rsp
);

	logic act0;
	logic act1;
	logic pick;
	// port preferred when both ask
	logic prio;
	logic locked;
	logic grant_q;

	assign act0 = req0.cyc && req0.stb;
	assign act1 = req1.cyc && req1.stb;

	always_comb begin
		if (act0 && act1) begin
			pick = prio;
		end else begin
			pick = act1;
		end
	end

	assign grant   = locked ? grant_q : pick;
	assign granted = grant ? req1 : req0;

	// lock on first request, release on the response cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			locked  <= 1'b0;
			grant_q <= 1'b0;
			prio    <= 1'b0;
		end else if (locked) begin
			if (busy_done) begin
				locked <= 1'b0;
				prio   <= ~grant_q;
			end
		end else if (act0 || act1) begin
			locked  <= 1'b1;
			grant_q <= pick;
		end
	end

	always_comb begin
		rsp0 = '0;
		rsp1 = '0;
		if (grant) begin
			rsp1 = rsp;
		end else begin
			rsp0 = rsp;
		end
	end

	// a response only goes out while its master still holds the bus
	a_rsp_to_owner: assert property (@(posedge clk) disable iff (reset)
		(rsp.ack || rsp.err) |-> locked && (grant_q ? act1 : act0))
		else $error("response without a locked, live owner");

endmodule

`default_nettype wire

/* hdl/smem_pkg.sv */
// types shared by the secure memory subsystem
// Wishbone request and response, DMA command and the memory operation

`default_nettype none

`include "smem_consts.svh"

package smem_pkg;

	// Wishbone classic master side, adr msb selects register space
	typedef struct packed {
		logic                        cyc;
		logic                        stb;
		logic                        we;
		logic [`SMEM_ADDR_BITS:0]    adr;
		logic [`SMEM_DATA_BITS-1:0]  dat;
	} wb_req_t;

	typedef struct packed {
		logic                        ack;
		logic                        err;
		logic [`SMEM_DATA_BITS-1:0]  dat;
	} wb_rsp_t;

	// DMA command as written to the command register
	typedef struct packed {
		logic [`SMEM_ADDR_BITS-1:0]  src;
		logic [`SMEM_ADDR_BITS-1:0]  dst;
		logic [`SMEM_LEN_BITS-1:0]   len;
		logic [`SMEM_DATA_BITS-2*`SMEM_ADDR_BITS-`SMEM_LEN_BITS-1:0] rsvd;
	} dma_cmd_t;

	// register write word, plain or DMA command
	typedef union packed {
		logic [`SMEM_DATA_BITS-1:0]  word;
		dma_cmd_t                    dma;
	} cmd_word_u;

	typedef struct packed {
		logic                        en;
		logic                        we;
		logic [`SMEM_ADDR_BITS-1:0]  addr;
		logic [`SMEM_DATA_BITS-1:0]  wdata;
	} mem_op_t;

endpackage

`default_nettype wire

/* hdl/smem_consts.svh */
// sizes and register offsets for the secure memory subsystem
// included by the package and by every module that sizes a port with them

`ifndef SMEM_CONSTS_SVH
`define SMEM_CONSTS_SVH

//======================================================================
// memory geometry
//======================================================================

// word address into the shared memory
`define SMEM_ADDR_BITS 10
`define SMEM_DEPTH 1024
`define SMEM_DATA_BITS 32

// DMA block length in words
`define SMEM_LEN_BITS 8

//======================================================================
// partition and register space
//======================================================================

// first word of domain 1 after reset
`define SMEM_PART_RESET 10'd512

// register select is adr bit 0 when the top adr bit is set
`define SMEM_REG_PART 1'b0
`define SMEM_REG_DMA 1'b1

`endif
